/* disp_pkg.sv */
`default_nettype none

package disp_pkg;

	localparam int NUM_TUBES    = 4;
	localparam int NUM_KEY_COLS = 4;
	localparam int NUM_KEY_ROWS = 4;
	localparam int DISP_CHARS   = 16;

	typedef logic [$clog2(NUM_TUBES)-1:0] tube_sel_t;
	typedef logic [3:0] bcd_t;
	typedef logic [NUM_TUBES-1:0] anode_t;	// One-hot tube select

	typedef logic [NUM_KEY_COLS-1:0] key_col_t;
	typedef logic [NUM_KEY_ROWS-1:0] key_row_t;
	typedef logic [$clog2(NUM_KEY_COLS)-1:0] key_col_idx_t;
	typedef logic [$clog2(NUM_KEY_ROWS)-1:0] key_row_idx_t;
	typedef logic [3:0] key_code_t;	// Column index above row index

	typedef logic [$clog2(DISP_CHARS)-1:0] disp_pos_t;
	typedef logic [7:0] disp_char_t;

	typedef struct packed {
		logic       valid;
		logic       to_text;	// Set for the character buffer, clear for tube digits
		logic [3:0] index;
		logic [7:0] value;
	} host_write_t;

	typedef struct packed {
		logic      valid;
		key_code_t code;
	} key_event_t;

endpackage

`default_nettype wire

/* display_scan.f */
scan_pkg.sv
disp_pkg.sv
scan_timer.sv
scan_sequencer.sv
in12_mux.sv
keypad_scanner.sv
ms6205_writer.sv
display_scan_top.sv
display_scan_checker.sv
tb_display_scan.sv

/* display_scan_checker.sv */
`default_nettype none

module display_scan_checker (
	input wire                          clock_1us,
	input wire                          rst,
	input wire scan_pkg::scan_strobes_t strobes,
	input wire disp_pkg::anode_t        in12_anode
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [5:0] strobe_bits;

	assign strobe_bits = strobes;	// Flat view of the six strobe fields

	strobes_exclusive: assert property (@(posedge clock_1us) disable iff (rst)
		$onehot0(strobe_bits))
		else $error("More than one scan strobe is active in the same cycle");

	strobes_single_cycle: assert property (@(posedge clock_1us) disable iff (rst)
		(strobe_bits != '0) |=> ((strobe_bits & $past(strobe_bits)) == '0))
		else $error("A scan strobe stayed high for more than one cycle");

	anode_follows_cathode: assert property (@(posedge clock_1us) disable iff (rst)
		strobes.cathode |-> ##2 strobes.anode)
		else $error("The anode strobe did not follow the cathode strobe after two cycles");

	anode_one_hot: assert property (@(posedge clock_1us) disable iff (rst)
		$onehot0(in12_anode))
		else $error("More than one tube anode is driven");

endmodule

// The top level carries both the strobe bundle and the anode latch
bind display_scan_top display_scan_checker i_checker (
	.clock_1us  (clock_1us),
	.rst        (rst),
	.strobes    (strobes),
	.in12_anode (in12_anode)
);

`default_nettype wire

/* display_scan_top.sv */
`default_nettype none

module display_scan_top (
	input  wire                        clock_1us,
	input  wire                        rst,
	input  wire disp_pkg::host_write_t host_wr,
	input  wire disp_pkg::key_row_t    key_rows,
	output disp_pkg::bcd_t             in12_cathode,
	output disp_pkg::anode_t           in12_anode,
	output disp_pkg::key_col_t         key_cols,
	output disp_pkg::key_event_t       key_evt,
	output disp_pkg::disp_pos_t        ms6205_addr,
	output disp_pkg::disp_char_t       ms6205_data,
	output logic                       ms6205_write_addr_n,
	output logic                       ms6205_write_data_n,
	output scan_pkg::seq_state_t       seq_state
);

	logic                    enable;
	scan_pkg::scan_strobes_t strobes;

	scan_timer u_timer (
		.clock_1us (clock_1us),
		.rst       (rst),
		.enable    (enable)
	);

	scan_sequencer u_sequencer (
		.clock_1us (clock_1us),
		.rst       (rst),
		.enable    (enable),
		.strobes   (strobes),
		.state     (seq_state)
	);

	in12_mux u_in12 (
		.clock_1us    (clock_1us),
		.rst          (rst),
		.strobes      (strobes),
		.host_wr      (host_wr),
		.in12_cathode (in12_cathode),
		.in12_anode   (in12_anode)
	);

	keypad_scanner u_keypad (
		.clock_1us (clock_1us),
		.rst       (rst),
		.strobes   (strobes),
		.key_rows  (key_rows),
		.key_cols  (key_cols),
		.key_evt   (key_evt)
	);

	ms6205_writer u_ms6205 (
		.clock_1us           (clock_1us),
		.rst                 (rst),
		.strobes             (strobes),
		.host_wr             (host_wr),
		.ms6205_addr         (ms6205_addr),
		.ms6205_data         (ms6205_data),
		.ms6205_write_addr_n (ms6205_write_addr_n),
		.ms6205_write_data_n (ms6205_write_data_n)
	);

endmodule

`default_nettype wire

/* in12_mux.sv */
`default_nettype none

module in12_mux (
	input  wire                     clock_1us,
	input  wire                     rst,
	input  wire scan_pkg::scan_strobes_t strobes,
	input  wire disp_pkg::host_write_t   host_wr,
	output disp_pkg::bcd_t          in12_cathode,
	output disp_pkg::anode_t        in12_anode
);

	disp_pkg::bcd_t      digits [disp_pkg::NUM_TUBES];
	disp_pkg::tube_sel_t tube;
	disp_pkg::tube_sel_t next_tube;

	assign next_tube = (tube == disp_pkg::tube_sel_t'(disp_pkg::NUM_TUBES - 1))
		? '0 : tube + 1'b1;

	always_ff @(posedge clock_1us) begin
		if (host_wr.valid && !host_wr.to_text && host_wr.index < disp_pkg::NUM_TUBES) begin
			digits[disp_pkg::tube_sel_t'(host_wr.index)] <= disp_pkg::bcd_t'(host_wr.value);
		end
	end

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			tube <= disp_pkg::tube_sel_t'(disp_pkg::NUM_TUBES - 1);	// First frame shows tube 0
			in12_cathode <= '0;
			in12_anode <= '0;
		end else begin
			if (strobes.cathode) begin
				tube <= next_tube;
				in12_cathode <= digits[next_tube];
			end
			if (strobes.anode) begin
				in12_anode <= disp_pkg::anode_t'(1) << tube;	// Same tube as the cathode latch
			end
		end
	end

endmodule

`default_nettype wire

/* keypad_scanner.sv */
`default_nettype none

module keypad_scanner (
	input  wire                     clock_1us,
	input  wire                     rst,
	input  wire scan_pkg::scan_strobes_t strobes,
	input  wire disp_pkg::key_row_t      key_rows,
	output disp_pkg::key_col_t      key_cols,
	output disp_pkg::key_event_t    key_evt
);

	disp_pkg::key_col_idx_t col;
	disp_pkg::key_col_idx_t next_col;
	disp_pkg::key_row_t     pressed;
	disp_pkg::key_row_t     new_rows;
	disp_pkg::key_row_idx_t low_row;
	disp_pkg::key_row_t [disp_pkg::NUM_KEY_COLS-1:0] last_rows;

	assign next_col = (col == disp_pkg::key_col_idx_t'(disp_pkg::NUM_KEY_COLS - 1))
		? '0 : col + 1'b1;
	assign pressed = ~key_rows;	// Rows pull low when a key closes
	assign new_rows = pressed & ~last_rows[col];

	// Walk downwards so the lowest row index wins
	always_comb begin
		low_row = '0;
		for (int r = disp_pkg::NUM_KEY_ROWS - 1; r >= 0; r--) begin
			if (new_rows[r]) begin
				low_row = disp_pkg::key_row_idx_t'(r);
			end
		end
	end

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			col <= disp_pkg::key_col_idx_t'(disp_pkg::NUM_KEY_COLS - 1);
			key_cols <= '1;
			last_rows <= '0;
			key_evt <= '0;
		end else begin
			key_evt.valid <= 1'b0;	// Events are single pulses
			if (strobes.kbd_write) begin
				col <= next_col;
				key_cols <= ~(disp_pkg::key_col_t'(1) << next_col);
			end
			if (strobes.kbd_read) begin
				last_rows[col] <= pressed;
				key_evt.valid <= |new_rows;
				key_evt.code <= {col, low_row};
			end
		end
	end

endmodule

`default_nettype wire

/* ms6205_writer.sv */
`default_nettype none

module ms6205_writer (
	input  wire                     clock_1us,
	input  wire                     rst,
	input  wire scan_pkg::scan_strobes_t strobes,
	input  wire disp_pkg::host_write_t   host_wr,
	output disp_pkg::disp_pos_t     ms6205_addr,
	output disp_pkg::disp_char_t    ms6205_data,
	output logic                    ms6205_write_addr_n,
	output logic                    ms6205_write_data_n
);

	disp_pkg::disp_char_t chars [disp_pkg::DISP_CHARS];
	disp_pkg::disp_pos_t  pos;

	assign ms6205_write_addr_n = ~strobes.disp_addr;
	assign ms6205_write_data_n = ~strobes.disp_data;

	always_ff @(posedge clock_1us) begin
		if (host_wr.valid && host_wr.to_text) begin
			chars[disp_pkg::disp_pos_t'(host_wr.index)] <= disp_pkg::disp_char_t'(host_wr.value);
		end
	end

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			pos <= '0;
			ms6205_addr <= '0;
			ms6205_data <= '0;
		end else begin
			if (strobes.disp_addr) begin
				ms6205_addr <= pos;
			end
			if (strobes.disp_data) begin
				ms6205_data <= chars[pos];
				pos <= (pos == disp_pkg::disp_pos_t'(disp_pkg::DISP_CHARS - 1))
					? '0 : pos + 1'b1;	// One position per frame
			end
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the display scan testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_display_scan -f display_scan.f -o sim_display_scan &&
./obj_dir/sim_display_scan | tee /dev/stderr | grep -qx "All checks passed" &&
echo "Simulation run passed" || { echo "Simulation run failed"; exit 1; }

/* scan_pkg.sv */
`default_nettype none

package scan_pkg;

	localparam int SCAN_PERIOD = 32;	// Cycles per scan frame
	localparam int ENABLE_HIGH = 16;	// Cycles of each frame with enable high

	typedef logic [$clog2(SCAN_PERIOD)-1:0] frame_cnt_t;

	typedef enum logic [2:0] {
		ST_IDLE        = 3'd0,
		ST_CATHODES    = 3'd1,
		ST_ANODES      = 3'd2,
		ST_KEYBOARD_WR = 3'd3,
		ST_MC_ADDR     = 3'd4,
		ST_MC_DATA     = 3'd5,
		ST_KEYBOARD_RD = 3'd6,
		ST_STOP        = 3'd7
	} seq_state_t;

	typedef struct packed {
		logic cathode;	// Tube digit latch
		logic anode;	// Tube select latch
		logic kbd_write;	// Keypad column drive
		logic kbd_read;	// Keypad row sample
		logic disp_addr;	// MS6205 address write
		logic disp_data;	// MS6205 data write
	} scan_strobes_t;

endpackage

`default_nettype wire

/* scan_sequencer.sv */
`default_nettype none

module scan_sequencer (
	input  wire                     clock_1us,
	input  wire                     rst,
	input  wire                     enable,
	output scan_pkg::scan_strobes_t strobes,
	output scan_pkg::seq_state_t    state
);

	scan_pkg::seq_state_t next_state;

	// Every write state waits until its own strobe has been seen
	always_comb begin
		next_state = state;
		case (state)
			scan_pkg::ST_IDLE:
				next_state = enable ? scan_pkg::ST_CATHODES : scan_pkg::ST_IDLE;
			scan_pkg::ST_CATHODES:
				next_state = strobes.cathode ? scan_pkg::ST_ANODES : scan_pkg::ST_CATHODES;
			scan_pkg::ST_ANODES:
				next_state = strobes.anode ? scan_pkg::ST_KEYBOARD_WR : scan_pkg::ST_ANODES;
			scan_pkg::ST_KEYBOARD_WR:
				next_state = strobes.kbd_write ? scan_pkg::ST_MC_ADDR
					: scan_pkg::ST_KEYBOARD_WR;
			scan_pkg::ST_MC_ADDR:
				next_state = strobes.disp_addr ? scan_pkg::ST_MC_DATA : scan_pkg::ST_MC_ADDR;
			scan_pkg::ST_MC_DATA:
				next_state = strobes.disp_data ? scan_pkg::ST_STOP : scan_pkg::ST_MC_DATA;
			scan_pkg::ST_STOP:
				next_state = enable ? scan_pkg::ST_STOP : scan_pkg::ST_KEYBOARD_RD;	// Hold out the frame
			scan_pkg::ST_KEYBOARD_RD:
				next_state = strobes.kbd_read ? scan_pkg::ST_IDLE : scan_pkg::ST_KEYBOARD_RD;
		endcase
	end

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			state <= scan_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// A strobe drops after one cycle even while its state is still current
	always_ff @(posedge clock_1us) begin
		if (rst) begin
			strobes <= '0;
		end else begin
			strobes.cathode <= (state == scan_pkg::ST_CATHODES) && enable
				&& !strobes.cathode;
			strobes.anode <= (state == scan_pkg::ST_ANODES) && enable
				&& !strobes.anode;
			strobes.kbd_write <= (state == scan_pkg::ST_KEYBOARD_WR) && enable
				&& !strobes.kbd_write;
			strobes.disp_addr <= (state == scan_pkg::ST_MC_ADDR) && enable
				&& !strobes.disp_addr;
			strobes.disp_data <= (state == scan_pkg::ST_MC_DATA) && enable
				&& !strobes.disp_data;
			strobes.kbd_read <= (state == scan_pkg::ST_KEYBOARD_RD) && !enable
				&& !strobes.kbd_read;	// Read happens in the low half of the frame
		end
	end

endmodule

`default_nettype wire

/* scan_timer.sv */
`default_nettype none

module scan_timer (
	input  wire  clock_1us,
	input  wire  rst,
	output logic enable
);

	scan_pkg::frame_cnt_t frame_cnt;

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			frame_cnt <= '0;
		end else if (frame_cnt == scan_pkg::frame_cnt_t'(scan_pkg::SCAN_PERIOD - 1)) begin
			frame_cnt <= '0;	// Start of the next frame
		end else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// Enable covers the first part of every frame
	assign enable = (frame_cnt < scan_pkg::ENABLE_HIGH);

endmodule

`default_nettype wire

/* tb_display_scan.sv */
`default_nettype none

module tb_display_scan;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES   = 16;
	localparam int RUN_FRAMES     = 60;
	localparam int FRAME          = scan_pkg::SCAN_PERIOD;
	localparam int TIMEOUT_CYCLES = 3000;	// Covers 60 frames of 32 cycles and reset with margin

	logic                   clock_1us;
	logic                   rst;
	disp_pkg::host_write_t  host_wr;
	disp_pkg::key_row_t     key_rows;
	disp_pkg::bcd_t         in12_cathode;
	disp_pkg::anode_t       in12_anode;
	disp_pkg::key_col_t     key_cols;
	disp_pkg::key_event_t   key_evt;
	disp_pkg::disp_pos_t    ms6205_addr;
	disp_pkg::disp_char_t   ms6205_data;
	logic                   ms6205_write_addr_n;
	logic                   ms6205_write_data_n;
	scan_pkg::seq_state_t   seq_state;

	disp_pkg::bcd_t         digit_copy [disp_pkg::NUM_TUBES];
	disp_pkg::disp_char_t   char_copy [disp_pkg::DISP_CHARS];
	logic                   key_down;
	disp_pkg::key_col_idx_t key_col;
	disp_pkg::key_row_idx_t key_row;
	disp_pkg::key_code_t    expected_code;
	integer                 seed;
	int                     cycle;
	int                     run_cycles;
	int                     addr_cycle;
	int                     events_before;
	int                     checks;
	int                     errors;
	int                     key_events;
	int                     addr_strobes;
	int                     data_strobes;

	display_scan_top i_dut (.*);

	// A closed key pulls its row low while its column is driven low
	assign key_rows = (key_down && !key_cols[key_col])
		? disp_pkg::key_row_t'(~(4'b0001 << key_row)) : '1;

	initial begin
		clock_1us = 1'b0;
		forever #4 clock_1us = ~clock_1us;
	end

	always @(posedge clock_1us) begin
		if (rst) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;	// Cycle 0 is the first cycle after reset release
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic scan_pkg::seq_state_t state_at_cycle(input int phase);
		if (phase == 0) return scan_pkg::ST_IDLE;
		if (phase <= 2) return scan_pkg::ST_CATHODES;
		if (phase <= 4) return scan_pkg::ST_ANODES;
		if (phase <= 6) return scan_pkg::ST_KEYBOARD_WR;
		if (phase <= 8) return scan_pkg::ST_MC_ADDR;
		if (phase <= 10) return scan_pkg::ST_MC_DATA;
		if (phase <= 16) return scan_pkg::ST_STOP;	// Enable falls at 16
		if (phase <= 18) return scan_pkg::ST_KEYBOARD_RD;
		return scan_pkg::ST_IDLE;
	endfunction

	function automatic disp_pkg::anode_t anode_for_frame(input int frame);
		return disp_pkg::anode_t'(1 << (frame % disp_pkg::NUM_TUBES));
	endfunction

	function automatic disp_pkg::bcd_t digit_for_frame(input int frame);
		return digit_copy[frame % disp_pkg::NUM_TUBES];
	endfunction

	function automatic disp_pkg::disp_char_t char_for_frame(input int frame);
		return char_copy[frame % disp_pkg::DISP_CHARS];
	endfunction

	function automatic disp_pkg::key_col_t cols_for_frame(input int frame);
		return disp_pkg::key_col_t'(~(1 << (frame % disp_pkg::NUM_KEY_COLS)));
	endfunction

	function automatic disp_pkg::key_code_t code_for_key(input disp_pkg::key_col_idx_t col,
		input disp_pkg::key_row_idx_t row);
		return disp_pkg::key_code_t'(col * disp_pkg::NUM_KEY_ROWS + row);
	endfunction

	task automatic hold_frames(input int frames);
		repeat (frames * FRAME) @(posedge clock_1us);
	endtask

	task automatic press_key(input disp_pkg::key_col_idx_t col,
		input disp_pkg::key_row_idx_t row);
		@(posedge clock_1us);
		#1;
		key_col = col;
		key_row = row;
		expected_code = code_for_key(col, row);
		key_down = 1'b1;
	endtask

	task automatic release_key();
		@(posedge clock_1us);
		#1;
		key_down = 1'b0;
	endtask

	// Outputs are compared on the falling edge in the middle of each cycle
	always @(negedge clock_1us) begin
		if (!rst) begin
			check_value("sequencer state", state_at_cycle(cycle % FRAME), seq_state);
			if (!ms6205_write_addr_n) begin
				addr_strobes++;
				addr_cycle = cycle;
				check_value("address strobe position", 8, cycle % FRAME);
				check_value("tube anode", anode_for_frame(cycle / FRAME), in12_anode);
				check_value("tube digit", digit_for_frame(cycle / FRAME), in12_cathode);
				check_value("keypad columns", cols_for_frame(cycle / FRAME), key_cols);
			end
			if (!ms6205_write_data_n) begin
				data_strobes++;
				check_value("address to data delay", 2, cycle - addr_cycle);
				check_value("display address", (cycle / FRAME) % disp_pkg::DISP_CHARS,
					ms6205_addr);
				if (cycle >= FRAME) begin	// Data bus still holds the previous frame's character
					check_value("display data", char_for_frame(cycle / FRAME - 1), ms6205_data);
				end
			end
			if (key_evt.valid) begin
				key_events++;
				check_value("key event position", 19, cycle % FRAME);
				check_value("key code", expected_code, key_evt.code);
			end
		end
	end

	initial begin
		run_cycles = 0;
		while (run_cycles < TIMEOUT_CYCLES) begin
			@(posedge clock_1us);
			run_cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles, %0d errors so far",
			TIMEOUT_CYCLES, errors);
		$display("Checks failed");
		$finish;
	end

	initial begin
		seed = 12974;
		rst = 1'b1;
		host_wr = '0;
		key_down = 1'b0;
		key_col = '0;
		key_row = '0;
		expected_code = '0;
		// Digits go in during reset and the last characters land before position 0 is shown
		for (int i = 0; i < disp_pkg::NUM_TUBES + disp_pkg::DISP_CHARS; i++) begin
			@(posedge clock_1us);
			#1;
			if (i == RESET_CYCLES - 1) begin
				check_value("reset address strobe", 1, ms6205_write_addr_n);
				check_value("reset data strobe", 1, ms6205_write_data_n);
				check_value("reset anode", 0, in12_anode);
				check_value("reset columns", 4'hf, key_cols);
				check_value("reset key event", 0, key_evt.valid);
				rst = 1'b0;
			end
			host_wr.valid = 1'b1;
			if (i < disp_pkg::NUM_TUBES) begin
				digit_copy[i] = disp_pkg::bcd_t'($unsigned($random(seed)) % 10);
				host_wr.to_text = 1'b0;
				host_wr.index = 4'(i);
				host_wr.value = 8'(digit_copy[i]);
			end else begin
				char_copy[i - disp_pkg::NUM_TUBES] = disp_pkg::disp_char_t'($random(seed));
				host_wr.to_text = 1'b1;
				host_wr.index = 4'(i - disp_pkg::NUM_TUBES);
				host_wr.value = char_copy[i - disp_pkg::NUM_TUBES];
			end
		end
		@(posedge clock_1us);
		#1;
		host_wr = '0;

		events_before = key_events;
		press_key(2'd2, 2'd1);
		wait (key_events == events_before + 1);
		hold_frames(8);	// Column 2 is read twice more while the key stays down
		check_value("no repeat while held", events_before + 1, key_events);
		release_key();
		hold_frames(4);
		press_key(2'd2, 2'd1);
		wait (key_events == events_before + 2);
		hold_frames(4);
		release_key();
		hold_frames(4);
		press_key(2'd1, 2'd3);
		wait (key_events == events_before + 3);
		hold_frames(4);
		release_key();

		wait (cycle >= RUN_FRAMES * FRAME);
		#1;
		check_value("key events", 3, key_events);
		check_value("address strobes", RUN_FRAMES, addr_strobes);
		check_value("data strobes", RUN_FRAMES, data_strobes);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
